/* logic/icache_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_fsm
    import icache_pkg::*;
    import l2_bus_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        fetch_req,
    input  fetch_addr_t fetch_addr,
    input  logic        flush,
    input  lookup_t     lookup,
    input  logic        last_beat,
    input  logic        timeout,
    output fetch_addr_t cur_addr,
    output l2_req_t     l2_req,
    output logic        fill,
    output logic        touch,
    output logic        fill_way,
    output logic        touch_way,
    output logic        flush_all,
    output logic        allocating,
    output logic        read_en,
    output logic        stall,
    output logic        fetch_valid,
    output logic        fetch_err
);

    typedef enum logic [1:0] {
        S_IDLE     = 2'b00,
        S_COMPARE  = 2'b01,
        S_ALLOCATE = 2'b11
    } state_t;

    state_t state, next_state;
    logic   cmp_hit;

    assign cmp_hit = (state == S_COMPARE) && lookup.hit;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:     if (fetch_req) next_state = S_COMPARE;
            S_COMPARE:  next_state = lookup.hit ? S_IDLE : S_ALLOCATE;
            S_ALLOCATE:
            begin
                if (timeout)
                    next_state = S_IDLE;        // abort, client gets fetch_err
                else if (last_beat)
                    next_state = S_COMPARE;     // line is in, look again
            end
            default:    next_state = S_IDLE;
        endcase
    end

    // request latch
    always_ff @(posedge clk)
    begin
        if ((state == S_IDLE) && fetch_req)
            cur_addr <= fetch_addr;
    end

    // victim captured on the miss decision
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            fill_way <= 1'b0;
        else if ((state == S_COMPARE) && !lookup.hit)
            fill_way <= lookup.victim_way;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            fetch_valid <= 1'b0;
            fetch_err   <= 1'b0;
        end
        else
        begin
            fetch_valid <= cmp_hit;     // lines up with the registered data read
            fetch_err   <= allocating && timeout;
        end
    end

    assign allocating = (state == S_ALLOCATE);
    assign stall      = (state != S_IDLE);

    assign touch     = cmp_hit;
    assign touch_way = lookup.hit_way;
    assign read_en   = cmp_hit;
    assign fill      = allocating && last_beat;

    // an abort leaves a half-written victim, so drop the valid bits
    assign flush_all = ((state == S_IDLE) && flush && !fetch_req) || (allocating && timeout);

    assign l2_req.read = allocating;
    assign l2_req.line = '{tag: cur_addr.tag, set_idx: cur_addr.set_idx};

    // client must respect stall
    assert property (@(posedge clk) disable iff (!nrst) stall |-> !fetch_req)
        else $error("fetch_req while stall is high");

    // a refilled line must hit on the compare that follows
    assert property (@(posedge clk) disable iff (!nrst) fill |=> lookup.hit)
        else $error("refilled line missed on the next compare");

endmodule

`default_nettype wire

/* logic/icache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_array
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        wr_en,
    input  logic [1:0]  wr_set,
    input  logic        wr_way,
    input  logic [1:0]  wr_word,
    input  word_t       wr_data,
    input  logic        rd_en,
    input  fetch_addr_t rd_addr,
    input  logic        rd_way,
    output word_t       rd_data
);

    word_t mem [NUM_SETS][NUM_WAYS][LINE_WORDS];

    // one word per L2 beat
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_set][wr_way][wr_word] <= wr_data;
    end

    // registered read, output holds between reads
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr.set_idx][rd_way][rd_addr.offset];
    end

endmodule

`default_nettype wire

/* logic/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int unsigned NUM_SETS   = 4;
    localparam int unsigned NUM_WAYS   = 2;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned TAG_W      = 24;

    localparam int unsigned SET_W    = $clog2(NUM_SETS);
    localparam int unsigned OFFSET_W = $clog2(LINE_WORDS);
    localparam int unsigned WORD_W   = 32;

    typedef logic [WORD_W-1:0] word_t;

    // 28-bit word address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [SET_W-1:0]    set_idx;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_t;

    // names one cache line
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [SET_W-1:0] set_idx;
    } line_addr_t;

    // tag store result for the latched request
    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;   // way to fill on a miss
    } lookup_t;

endpackage

`default_nettype wire

/* logic/icache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  fetch_addr_t cur_addr,
    input  logic        fill,
    input  logic        fill_way,
    input  logic        touch,
    input  logic        touch_way,
    input  logic        flush_all,
    output lookup_t     lookup
);

    logic [TAG_W-1:0]                   tags [NUM_SETS][NUM_WAYS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]  valid;
    logic [NUM_SETS-1:0]                lru;    // way to replace next

    logic [SET_W-1:0]    idx;
    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] way_hit;

    assign idx       = cur_addr.set_idx;
    assign set_valid = valid[idx];

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
            way_hit[w] = set_valid[w] && (tags[idx][w] == cur_addr.tag);
    end

    assign lookup.hit     = |way_hit;
    assign lookup.hit_way = way_hit[1];

    // empty way first, else the LRU choice
    always_comb
    begin
        if (!set_valid[0])
            lookup.victim_way = 1'b0;
        else if (!set_valid[1])
            lookup.victim_way = 1'b1;
        else
            lookup.victim_way = lru[idx];
    end

    always_ff @(posedge clk)
    begin
        if (fill)
            tags[idx][fill_way] <= cur_addr.tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            valid <= '0;
        else if (flush_all)
            valid <= '0;
        else if (fill)
            valid[idx][fill_way] <= 1'b1;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lru <= '0;
        else if (fill)
            lru[idx] <= ~fill_way;      // new line is most recent
        else if (touch)
            lru[idx] <= ~touch_way;
    end

    // one copy of a line per set at most
    assert property (@(posedge clk) disable iff (!nrst) $onehot0(way_hit))
        else $error("both ways hit in set %0d", idx);

    // refill must land in the way chosen at the miss
    assert property (@(posedge clk) disable iff (!nrst) fill |-> fill_way == lookup.victim_way)
        else $error("fill way differs from victim way");

endmodule

`default_nettype wire

/* logic/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
    import l2_bus_pkg::*;
#(
    parameter int unsigned L2_WAIT_LIMIT = 16
)
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        fetch_req,
    input  fetch_addr_t fetch_addr,
    input  logic        flush,
    output logic        stall,
    output logic        fetch_valid,
    output word_t       fetch_data,
    output logic        fetch_err,
    output l2_req_t     l2_req,
    input  l2_resp_t    l2_resp
);

    fetch_addr_t cur_addr;
    lookup_t     lookup;
    logic        fill, fill_way;
    logic        touch, touch_way;
    logic        flush_all;
    logic        allocating;
    logic        read_en;
    logic        last_beat, timeout;
    logic [1:0]  word_idx;

    icache_ctrl_fsm u_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .flush       (flush),
        .lookup      (lookup),
        .last_beat   (last_beat),
        .timeout     (timeout),
        .cur_addr    (cur_addr),
        .l2_req      (l2_req),
        .fill        (fill),
        .touch       (touch),
        .fill_way    (fill_way),
        .touch_way   (touch_way),
        .flush_all   (flush_all),
        .allocating  (allocating),
        .read_en     (read_en),
        .stall       (stall),
        .fetch_valid (fetch_valid),
        .fetch_err   (fetch_err)
    );

    icache_tag_store u_tags (
        .clk       (clk),
        .nrst      (nrst),
        .cur_addr  (cur_addr),
        .fill      (fill),
        .fill_way  (fill_way),
        .touch     (touch),
        .touch_way (touch_way),
        .flush_all (flush_all),
        .lookup    (lookup)
    );

    // refill beats go to the victim way of the latched set
    icache_data_array u_data (
        .clk     (clk),
        .wr_en   (l2_resp.beat && allocating),
        .wr_set  (cur_addr.set_idx),
        .wr_way  (fill_way),
        .wr_word (word_idx),
        .wr_data (l2_resp.data),
        .rd_en   (read_en),
        .rd_addr (cur_addr),
        .rd_way  (lookup.hit_way),
        .rd_data (fetch_data)
    );

    refill_timer #(
        .L2_WAIT_LIMIT (L2_WAIT_LIMIT)
    ) u_timer (
        .clk       (clk),
        .nrst      (nrst),
        .active    (allocating),
        .beat      (l2_resp.beat),
        .word_idx  (word_idx),
        .last_beat (last_beat),
        .timeout   (timeout)
    );

endmodule

`default_nettype wire

/* logic/l2_bus_pkg.sv */
`default_nettype none

package l2_bus_pkg;

    import icache_pkg::*;

    // one read returns a full line, word 0 first
    localparam int unsigned L2_BEATS = LINE_WORDS;

    typedef struct packed {
        logic       read;   // held for the whole refill
        line_addr_t line;
    } l2_req_t;

    typedef struct packed {
        logic  beat;        // one-cycle strobe per word
        word_t data;
    } l2_resp_t;

endpackage

`default_nettype wire

/* logic/refill_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_timer
    import icache_pkg::*;
    import l2_bus_pkg::*;
#(
    parameter int unsigned L2_WAIT_LIMIT = 16
)
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       active,
    input  logic       beat,
    output logic [1:0] word_idx,
    output logic       last_beat,
    output logic       timeout
);

    localparam int unsigned CNT_W = $clog2(L2_WAIT_LIMIT);

    logic [OFFSET_W-1:0] beat_cnt;
    logic [CNT_W-1:0]    idle_cnt;     // cycles since read start or last beat

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            beat_cnt <= '0;
        else if (!active)
            beat_cnt <= '0;
        else if (beat)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            idle_cnt <= '0;
        else if (!active || beat)
            idle_cnt <= '0;
        else
            idle_cnt <= idle_cnt + 1'b1;
    end

    assign word_idx  = beat_cnt;
    assign last_beat = active && beat && (beat_cnt == OFFSET_W'(L2_BEATS - 1));
    assign timeout   = active && !beat && (idle_cnt == CNT_W'(L2_WAIT_LIMIT - 1));

    // L2 only answers an open read
    assert property (@(posedge clk) disable iff (!nrst) beat |-> active)
        else $error("l2 beat outside a refill");

endmodule

`default_nettype wire

/* sources.f */
logic/icache_pkg.sv
logic/l2_bus_pkg.sv
logic/icache_ctrl_fsm.sv
logic/icache_tag_store.sv
logic/icache_data_array.sv
logic/refill_timer.sv
logic/icache_top.sv
verification/l2_mem_model.sv
verification/icache_tb.sv

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import icache_pkg::*;
    import l2_bus_pkg::*;
();

    localparam int unsigned WAIT_LIMIT = 16;
    localparam int          DONE_MAX   = 80;    // cycles allowed per wait

    logic        clk;
    logic        nrst;
    logic        fetch_req;
    fetch_addr_t fetch_addr;
    logic        flush;
    logic        stall;
    logic        fetch_valid;
    word_t       fetch_data;
    logic        fetch_err;
    l2_req_t     l2_req;
    l2_resp_t    l2_resp;
    logic        withhold;
    logic        l2_stuck;

    integer      seed = 32'h4686_2006;
    int          errors;
    int          timeouts;
    int          l2_reads;
    logic        read_q;
    logic        exp_hit;
    logic        exp_miss;
    logic        exp_err;
    fetch_addr_t acc_addr;
    logic        acc_err;
    fetch_addr_t pool [8];

    icache_top #(
        .L2_WAIT_LIMIT (WAIT_LIMIT)
    ) dut (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .flush       (flush),
        .stall       (stall),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .fetch_err   (fetch_err),
        .l2_req      (l2_req),
        .l2_resp     (l2_resp)
    );

    l2_mem_model u_l2 (
        .clk      (clk),
        .nrst     (nrst),
        .withhold (withhold),
        .l2_req   (l2_req),
        .l2_resp  (l2_resp),
        .stuck    (l2_stuck)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one count per rising read
    always @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            read_q   <= 1'b0;
            l2_reads <= 0;
        end
        else
        begin
            read_q <= l2_req.read;
            if (l2_req.read && !read_q)
                l2_reads <= l2_reads + 1;
        end
    end

    always @(posedge clk)
    begin
        if (nrst && fetch_req && !stall)
        begin
            acc_addr <= fetch_addr;     // address the result belongs to
            acc_err  <= exp_err;
        end
    end

    function automatic word_t expected_word(fetch_addr_t a);
        return {4'h0, a} ^ 32'hC0DE_0000;
    endfunction

    function automatic void report_error(string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endfunction

    assert property (@(posedge clk) disable iff (!nrst)
        fetch_valid |-> fetch_data == expected_word(acc_addr))
        else report_error("fetch_data does not match the word address");

    assert property (@(posedge clk) disable iff (!nrst)
        l2_req.read |-> l2_req.line == {acc_addr.tag, acc_addr.set_idx})
        else report_error("L2 read names the wrong line");

    assert property (@(posedge clk) disable iff (!nrst)
        fetch_req && !stall && exp_hit |-> ##1 !l2_req.read ##1 (fetch_valid && !l2_req.read))
        else report_error("hit not answered two edges after acceptance");

    assert property (@(posedge clk) disable iff (!nrst)
        fetch_req && !stall && exp_miss |-> ##2 l2_req.read)
        else report_error("miss did not start an L2 read");

    assert property (@(posedge clk) disable iff (!nrst) fetch_req && !stall |=> stall)
        else report_error("stall did not rise after acceptance");

    assert property (@(posedge clk) disable iff (!nrst) fetch_valid |-> !stall && !fetch_err)
        else report_error("fetch_valid with stall or fetch_err high");

    assert property (@(posedge clk) disable iff (!nrst) fetch_err |-> acc_err && !stall)
        else report_error("unexpected fetch_err or stall high after abort");

    task automatic fetch_word(input fetch_addr_t a, input logic hit_e, input logic miss_e,
                              input logic err_e);
        int reads_before;
        int n;
        n = 0;
        while (stall && n < DONE_MAX)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (stall)
        begin
            timeouts++;
            $display("timeout: cache stayed busy before fetch of %h", a);
            return;
        end
        reads_before = l2_reads;
        exp_hit      = hit_e;
        exp_miss     = miss_e;
        exp_err      = err_e;
        fetch_addr   = a;
        fetch_req    = 1'b1;
        @(posedge clk);
        #2;
        fetch_req = 1'b0;
        n = 0;
        while (!fetch_valid && !fetch_err && n < DONE_MAX)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!fetch_valid && !fetch_err)
        begin
            timeouts++;
            $display("timeout: no fetch_valid or fetch_err for address %h", a);
        end
        else
        begin
            assert (fetch_err == err_e)
                else report_error("fetch ended with the wrong kind of response");
            if (hit_e || miss_e)
                assert (l2_reads == reads_before + (miss_e ? 1 : 0))
                    else report_error("wrong number of L2 reads for this fetch");
        end
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
    endtask

    initial
    begin
        fetch_addr_t a;
        fetch_addr_t b;
        fetch_addr_t c;
        fetch_addr_t x;
        nrst       = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        flush      = 1'b0;
        withhold   = 1'b0;
        exp_hit    = 1'b0;
        exp_miss   = 1'b0;
        exp_err    = 1'b0;
        errors     = 0;
        timeouts   = 0;
        for (int i = 0; i < 8; i++)
            pool[i] = {24'h00_C000 + 24'(i) * 24'h000111, 2'(i), 2'd0};
        repeat (3) @(posedge clk);
        #2;
        nrst = 1'b1;
        @(posedge clk);
        #2;

        a = {24'h00A001, 2'd0, 2'd1};
        fetch_word(a, 1'b0, 1'b1, 1'b0);    // cold miss
        fetch_word(a, 1'b1, 1'b0, 1'b0);
        a.offset = 2'd3;
        fetch_word(a, 1'b1, 1'b0, 1'b0);

        flush_cache();
        fetch_word(a, 1'b0, 1'b1, 1'b0);

        // A B A C in set 1 leaves B as the victim
        flush_cache();
        a = {24'h00A100, 2'd1, 2'd0};
        b = {24'h00B100, 2'd1, 2'd1};
        c = {24'h00C100, 2'd1, 2'd2};
        fetch_word(a, 1'b0, 1'b1, 1'b0);
        fetch_word(b, 1'b0, 1'b1, 1'b0);
        fetch_word(a, 1'b1, 1'b0, 1'b0);
        fetch_word(c, 1'b0, 1'b1, 1'b0);
        fetch_word(a, 1'b1, 1'b0, 1'b0);
        fetch_word(b, 1'b0, 1'b1, 1'b0);

        withhold = 1'b1;
        x = {24'h00D200, 2'd2, 2'd2};
        fetch_word(x, 1'b0, 1'b1, 1'b1);    // watchdog abort
        withhold = 1'b0;
        fetch_word(x, 1'b0, 1'b1, 1'b0);

        for (int i = 0; i < 200; i++)
        begin
            x = pool[{$random(seed)} % 8];
            x.offset = 2'($random(seed));
            fetch_word(x, 1'b0, 1'b0, 1'b0);
        end

        repeat (2) @(posedge clk);
        if (l2_stuck)
            timeouts++;
        $display("errors: %0d, timeouts: %0d, l2 reads: %0d", errors, timeouts, l2_reads);
        if (errors == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/l2_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model
    import icache_pkg::*;
    import l2_bus_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     withhold,
    input  l2_req_t  l2_req,
    output l2_resp_t l2_resp,
    output logic     stuck
);

    localparam int READ_WAIT_MAX = 64;

    integer seed = 32'h4686_2006;

    // memory content is the word address xor a fixed pattern
    function automatic word_t line_word(line_addr_t line, int w);
        return {4'h0, line.tag, line.set_idx, 2'(w)} ^ 32'hC0DE_0000;
    endfunction

    task automatic send_line();
        line_addr_t line;
        int         lat;
        int         gap;
        line = l2_req.line;
        lat  = 1 + {$random(seed)} % 3;
        repeat (lat - 1)
        begin
            @(posedge clk);
            #2;
        end
        for (int w = 0; w < LINE_WORDS; w++)
        begin
            l2_resp.beat = 1'b1;
            l2_resp.data = line_word(line, w);
            @(posedge clk);
            #2;
            l2_resp.beat = 1'b0;
            gap = {$random(seed)} % 2;
            if (gap != 0 && w < LINE_WORDS - 1)     // idle cycle between beats
            begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    // no beats, just wait for the cache to give up
    task automatic ignore_read();
        int n;
        n = 0;
        while (l2_req.read && n < READ_WAIT_MAX)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (l2_req.read)
        begin
            stuck = 1'b1;
            $display("L2 model: read request still open after %0d cycles", READ_WAIT_MAX);
        end
    endtask

    initial
    begin
        l2_resp = '0;
        stuck   = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            if (nrst && l2_req.read)
            begin
                if (withhold)
                    ignore_read();
                else
                    send_line();
            end
        end
    end

endmodule

`default_nettype wire
